//--- source/noc_loop_macros.svh
// Build-time constants for the loopback subsystem.
// Include this file in any source that needs block counts or register addresses.

`ifndef NOC_LOOP_MACROS_SVH
`define NOC_LOOP_MACROS_SVH

// Number of loopback blocks behind the router
`define NOC_NUM_BLOCKS 4

// log2 of the block count, low dst_sid bits used as lane select
`define NOC_LANE_BITS 2

// Settings register addresses
`define NOC_REG_NEXT_DST  8'd128
`define NOC_REG_SRC_SID   8'd129
`define NOC_REG_CLEAR_SEQ 8'd130

// Entries in each block's stream FIFO
`define NOC_FIFO_DEPTH 2

`endif

//--- source/chdr_pkg.sv
// Packet types for the 64-bit stream.
// The same word is read either as a CHDR header or as two 32-bit samples.

package chdr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Header layout, most significant field first
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [1:0]  pkt_type;
    logic        has_time;
    logic        eob;
    logic [11:0] seqnum;
    logic [15:0] length;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } chdr_hdr_t;

  // Payload view of a data beat
  typedef struct packed {
    logic [31:0] sample_hi;
    logic [31:0] sample_lo;
  } chdr_pld_t;

  ////////////////////////////////////////////////////////////////////////////
  // One 64-bit word, header or payload depending on position in packet
  ////////////////////////////////////////////////////////////////////////////
  typedef union packed {
    chdr_hdr_t hdr;
    chdr_pld_t pld;
  } chdr_word_u;

  // Stream beat, forward direction only
  // Ready runs as a separate wire
  typedef struct packed {
    chdr_word_u data;
    logic       last;
    logic       valid;
  } axis_beat_t;

endpackage

//--- source/block_cfg_pkg.sv
// Control types for the loopback blocks.
// Covers the settings write bus and the per-block register set.

`include "noc_loop_macros.svh"

package block_cfg_pkg;

  // Settings write, strobe qualified
  // blk picks the target block at the router
  typedef struct packed {
    logic                        stb;
    logic [`NOC_LANE_BITS-1:0]   blk;
    logic [7:0]                  addr;
    logic [31:0]                 data;
  } set_bus_t;

  // Registers held inside each block
  typedef struct packed {
    logic [15:0] next_dst;
    logic [15:0] src_sid;
  } block_cfg_t;

endpackage

//--- source/stream_router.sv
// Steers whole packets to one loopback block picked by the header dst_sid.
// Also fans the settings bus out, with the strobe sent to the addressed block only.

`timescale 1ns/10ps
`include "noc_loop_macros.svh"

module stream_router
  import chdr_pkg::*;
  import block_cfg_pkg::*;
(
  input  logic                                ce_clk,
  input  logic                                i_arst_n,
  input  axis_beat_t                          i_in,
  output logic                                o_in_ready,
  input  set_bus_t                            i_set,
  output axis_beat_t [`NOC_NUM_BLOCKS-1:0]    o_lane_beat,
  input  logic       [`NOC_NUM_BLOCKS-1:0]    i_lane_ready,
  output set_bus_t   [`NOC_NUM_BLOCKS-1:0]    o_lane_set
);

  localparam int NB = `NOC_NUM_BLOCKS;
  localparam int LB = `NOC_LANE_BITS;

  logic          in_pkt;
  logic [LB-1:0] lane_q;
  logic [LB-1:0] hdr_lane;
  logic [LB-1:0] sel;
  logic          xfer;

  // Lane comes from the header while idle, from the latch mid-packet
  assign hdr_lane   = i_in.data.hdr.dst_sid[LB-1:0];
  assign sel        = in_pkt ? lane_q : hdr_lane;
  assign o_in_ready = i_lane_ready[sel];
  assign xfer       = i_in.valid && o_in_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Packet tracking
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_pkt <= 1'b0;
      lane_q <= '0;
    end else if (xfer) begin
      if (i_in.last) begin
        in_pkt <= 1'b0;
      end else if (!in_pkt) begin
        // Header of a multi-beat packet opens the lane
        in_pkt <= 1'b1;
        lane_q <= hdr_lane;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lane fan-out
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < NB; k++) begin
      o_lane_beat[k].data  = i_in.data;
      o_lane_beat[k].last  = i_in.last;
      o_lane_beat[k].valid = i_in.valid && (sel == LB'(k));

      // Only the strobe differs between lanes
      o_lane_set[k]     = i_set;
      o_lane_set[k].stb = i_set.stb && (i_set.blk == LB'(k));
    end
  end

endmodule

//--- source/loopback_block.sv
// One loopback block: settings registers, a small stream FIFO and header rewrite.
// Headers leave with the programmed dst/src IDs and the block's own sequence count.

`timescale 1ns/10ps
`include "noc_loop_macros.svh"

module loopback_block
  import chdr_pkg::*;
  import block_cfg_pkg::*;
(
  input  logic       ce_clk,
  input  logic       i_arst_n,
  input  axis_beat_t i_beat,
  output logic       o_ready,
  input  set_bus_t   i_set,
  output axis_beat_t o_beat,
  input  logic       i_ready
);

  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  block_cfg_t       cfg;
  logic             clr_seq;
  logic [11:0]      seq;

  chdr_word_u       mem_data [DEPTH];
  logic [DEPTH-1:0] mem_last;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic             out_in_pkt;
  chdr_word_u       head_word;
  chdr_hdr_t        new_hdr;

  ////////////////////////////////////////////////////////////////////////////
  // Settings registers
  ////////////////////////////////////////////////////////////////////////////
  // Clear is a bare strobe, data ignored
  assign clr_seq = i_set.stb && (i_set.addr == `NOC_REG_CLEAR_SEQ);

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cfg <= '0;
    end else if (i_set.stb) begin
      if (i_set.addr == `NOC_REG_NEXT_DST) begin
        cfg.next_dst <= i_set.data[15:0];
      end else if (i_set.addr == `NOC_REG_SRC_SID) begin
        cfg.src_sid <= i_set.data[15:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stream FIFO
  ////////////////////////////////////////////////////////////////////////////
  assign o_ready = (count != CNT_W'(DEPTH));
  assign push    = i_beat.valid && o_ready;
  assign pop     = o_beat.valid && i_ready;

  always_ff @(posedge ce_clk) begin
    if (push) begin
      mem_data[wr_ptr] <= i_beat.data;
      mem_last[wr_ptr] <= i_beat.last;
    end
  end

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Output side packet position and sequence count
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_in_pkt <= 1'b0;
      seq        <= '0;
    end else begin
      if (pop) begin
        out_in_pkt <= !o_beat.last;
      end
      // A clear beats a header leaving in the same cycle
      if (clr_seq) begin
        seq <= '0;
      end else if (pop && !out_in_pkt) begin
        seq <= seq + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Header rewrite
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    head_word       = mem_data[rd_ptr];
    new_hdr         = head_word.hdr;
    new_hdr.seqnum  = seq;
    new_hdr.src_sid = cfg.src_sid;
    new_hdr.dst_sid = cfg.next_dst;

    o_beat.valid = (count != '0);
    o_beat.last  = mem_last[rd_ptr];
    if (out_in_pkt) begin
      o_beat.data.pld = head_word.pld;
    end else begin
      o_beat.data.hdr = new_hdr;
    end
  end

endmodule

//--- source/stream_merger.sv
// Round-robin packet merger from all block return lanes into one stream.
// A grant stays locked until its tlast transfers, so packets never interleave.

`timescale 1ns/10ps
`include "noc_loop_macros.svh"

module stream_merger
  import chdr_pkg::*;
(
  input  logic                                ce_clk,
  input  logic                                i_arst_n,
  input  axis_beat_t [`NOC_NUM_BLOCKS-1:0]    i_beat,
  output logic       [`NOC_NUM_BLOCKS-1:0]    o_ready,
  output axis_beat_t                          o_out,
  input  logic                                i_out_ready
);

  localparam int NB = `NOC_NUM_BLOCKS;
  localparam int LB = `NOC_LANE_BITS;

  logic          locked;
  logic [LB-1:0] grant;
  logic [LB-1:0] last_win;
  logic [LB-1:0] pick;
  logic          any_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////////////////////
  // Search starts one past the last winner, which is checked last
  always_comb begin : rr_pick
    logic [LB-1:0] idx;
    pick      = last_win;
    any_valid = 1'b0;
    idx       = '0;
    for (int i = 1; i <= NB; i++) begin
      idx = last_win + LB'(i);
      if (!any_valid && i_beat[idx].valid) begin
        pick      = idx;
        any_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      locked   <= 1'b0;
      grant    <= '0;
      last_win <= LB'(NB - 1);
    end else if (!locked) begin
      if (any_valid) begin
        locked <= 1'b1;
        grant  <= pick;
      end
    end else if (o_out.valid && i_out_ready && o_out.last) begin
      // Packet done, next search moves past this lane
      locked   <= 1'b0;
      last_win <= grant;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////
  assign o_out.data  = i_beat[grant].data;
  assign o_out.last  = i_beat[grant].last;
  assign o_out.valid = locked && i_beat[grant].valid;

  // Ungranted lanes are held off
  always_comb begin
    for (int k = 0; k < NB; k++) begin
      o_ready[k] = locked && (grant == LB'(k)) && i_out_ready;
    end
  end

endmodule

//--- source/noc_loop_top.sv
// Top of the loopback subsystem in the ce_clk domain.
// Router feeds NOC_NUM_BLOCKS loopback blocks, merger collects their packets.

`timescale 1ns/10ps
`include "noc_loop_macros.svh"

module noc_loop_top
  import chdr_pkg::*;
  import block_cfg_pkg::*;
(
  input  logic       ce_clk,
  input  logic       i_arst_n,
  input  axis_beat_t i_in,
  output logic       o_in_ready,
  output axis_beat_t o_out,
  input  logic       i_out_ready,
  input  set_bus_t   i_set
);

  axis_beat_t [`NOC_NUM_BLOCKS-1:0] lane_beat;
  set_bus_t   [`NOC_NUM_BLOCKS-1:0] lane_set;
  logic       [`NOC_NUM_BLOCKS-1:0] lane_ready;
  axis_beat_t [`NOC_NUM_BLOCKS-1:0] ret_beat;
  logic       [`NOC_NUM_BLOCKS-1:0] ret_ready;

  stream_router inst_router (
    .ce_clk       (ce_clk),
    .i_arst_n     (i_arst_n),
    .i_in         (i_in),
    .o_in_ready   (o_in_ready),
    .i_set        (i_set),
    .o_lane_beat  (lane_beat),
    .i_lane_ready (lane_ready),
    .o_lane_set   (lane_set)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Loopback blocks
  ////////////////////////////////////////////////////////////////////////////
  for (genvar k = 0; k < `NOC_NUM_BLOCKS; k++) begin : g_block
    loopback_block inst_block (
      .ce_clk   (ce_clk),
      .i_arst_n (i_arst_n),
      .i_beat   (lane_beat[k]),
      .o_ready  (lane_ready[k]),
      .i_set    (lane_set[k]),
      .o_beat   (ret_beat[k]),
      .i_ready  (ret_ready[k])
    );
  end

  stream_merger inst_merger (
    .ce_clk      (ce_clk),
    .i_arst_n    (i_arst_n),
    .i_beat      (ret_beat),
    .o_ready     (ret_ready),
    .o_out       (o_out),
    .i_out_ready (i_out_ready)
  );

endmodule

//--- test/noc_loop_checker.sv
// Reference model and scoreboard for the loopback testbench.
// Samples transfers mid-cycle, predicts every output beat and reports each test.

`timescale 1ns/10ps
`include "noc_loop_macros.svh"

module noc_loop_checker
  import chdr_pkg::*;
  import block_cfg_pkg::*;
(
  input  logic       ce_clk,
  input  logic       i_arst_n,
  input  axis_beat_t i_in,
  input  logic       i_in_ready,
  input  set_bus_t   i_set,
  input  axis_beat_t i_out,
  input  logic       i_out_ready,
  input  logic       i_test_end,
  input  int         i_test_num,
  input  int         i_timeouts,
  output int         o_pending,
  output int         o_errors,
  output int         o_tests_run,
  output int         o_tests_failed
);

  localparam int NB = `NOC_NUM_BLOCKS;
  localparam int LB = `NOC_LANE_BITS;

  // Per-block queues of {is_header, last, word} entries
  logic [65:0]   exp_q [NB][$];
  logic [15:0]   dst_m [NB];
  logic [15:0]   src_m [NB];
  logic [11:0]   seq_m [NB];
  logic          seen_input;
  logic          in_open;
  logic [LB-1:0] in_blk;
  logic          out_open;
  int            out_blk;
  int            err_mark;
  int            to_mark;

  function automatic string test_name(input int num);
    case (num)
      1:       return "reset state";
      2:       return "header rewrite";
      3:       return "sequence numbering";
      4:       return "random traffic";
      5:       return "whole packets";
      6:       return "settings isolation";
      default: return "unnamed";
    endcase
  endfunction

  task automatic mismatch(input string sig, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error at %0d ns: %s expected %0h, got %0h", $time, sig, exp, act);
    o_errors++;
  endtask

  task automatic fail(input string msg);
    $display("Check failed at %0d ns: %s", $time, msg);
    o_errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output side check against the model's header fields
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_output();
    chdr_hdr_t   exp_hdr;
    logic [63:0] exp_word;
    logic [65:0] ent;
    if (!out_open) begin
      out_blk = -1;
      for (int b = 0; b < NB; b++) begin
        if (src_m[b] == i_out.data.hdr.src_sid) begin
          out_blk = b;
        end
      end
      if (out_blk < 0) begin
        fail($sformatf("header with src_sid %0h belongs to no block", i_out.data.hdr.src_sid));
      end else if (exp_q[out_blk].size() == 0) begin
        fail($sformatf("block %0d sent a packet that never went in", out_blk));
      end else begin
        ent = exp_q[out_blk].pop_front();
        o_pending--;
        if (!ent[65]) begin
          fail($sformatf("block %0d started a packet inside another one", out_blk));
        end
        exp_hdr         = ent[63:0];
        exp_hdr.seqnum  = seq_m[out_blk];
        exp_hdr.src_sid = src_m[out_blk];
        exp_hdr.dst_sid = dst_m[out_blk];
        exp_word        = exp_hdr;
        if (i_out.data != exp_word) mismatch("o_out.data", exp_word, i_out.data);
        if (i_out.last != ent[64]) mismatch("o_out.last", 64'(ent[64]), 64'(i_out.last));
        seq_m[out_blk] = seq_m[out_blk] + 12'd1;
      end
    end else if (out_blk >= 0) begin
      if (exp_q[out_blk].size() == 0) begin
        fail($sformatf("block %0d sent more beats than went in", out_blk));
      end else begin
        ent = exp_q[out_blk].pop_front();
        o_pending--;
        if (ent[65]) begin
          fail($sformatf("packet from block %0d runs into the next header", out_blk));
        end
        if (i_out.data != ent[63:0]) mismatch("o_out.data", ent[63:0], i_out.data);
        if (i_out.last != ent[64]) mismatch("o_out.last", 64'(ent[64]), 64'(i_out.last));
      end
    end
    out_open = !i_out.last;
  endtask

  // Close the running test and print its line
  task automatic close_test();
    if (o_pending != 0) fail($sformatf("%0d beats went in and never came out", o_pending));
    o_tests_run++;
    if (o_errors == err_mark && i_timeouts == to_mark) begin
      $display("test %0d %s: ok", i_test_num, test_name(i_test_num));
    end else begin
      o_tests_failed++;
      $display("test %0d %s: failed, %0d errors, %0d timeouts", i_test_num,
               test_name(i_test_num), o_errors - err_mark, i_timeouts - to_mark);
    end
    err_mark = o_errors;
    to_mark  = i_timeouts;
  endtask

  initial begin
    seen_input     = 1'b0;
    in_open        = 1'b0;
    in_blk         = '0;
    out_open       = 1'b0;
    out_blk        = -1;
    err_mark       = 0;
    to_mark        = 0;
    o_pending      = 0;
    o_errors       = 0;
    o_tests_run    = 0;
    o_tests_failed = 0;
    for (int b = 0; b < NB; b++) begin
      dst_m[b] = '0;
      src_m[b] = '0;
      seq_m[b] = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transfers sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge ce_clk) begin
    if (i_arst_n) begin
      if (i_in.valid) begin
        seen_input = 1'b1;
      end else if (!seen_input) begin
        // Idle after reset
        if (i_out.valid) mismatch("o_out.valid", 64'd0, 64'd1);
        if (!i_in_ready) mismatch("o_in_ready", 64'd1, 64'd0);
      end
      if (i_out.valid && i_out_ready) check_output();
      if (i_in.valid && i_in_ready) begin
        if (!in_open) begin
          in_blk = i_in.data.hdr.dst_sid[LB-1:0];
        end
        exp_q[in_blk].push_back({!in_open, i_in.last, i_in.data});
        o_pending++;
        in_open = !i_in.last;
      end
      // Register writes land after this cycle's output
      if (i_set.stb) begin
        if (i_set.addr == `NOC_REG_NEXT_DST) begin
          dst_m[i_set.blk] = i_set.data[15:0];
        end else if (i_set.addr == `NOC_REG_SRC_SID) begin
          src_m[i_set.blk] = i_set.data[15:0];
        end else if (i_set.addr == `NOC_REG_CLEAR_SEQ) begin
          seq_m[i_set.blk] = '0;
        end
      end
      if (i_test_end) close_test();
    end
  end

endmodule

//--- test/tb_noc_loop.sv
// Top-level testbench for the loopback subsystem.
// Drives random packets, settings writes and back-pressure; the checker scores the output.

`timescale 1ns/10ps
`include "noc_loop_macros.svh"

module tb_noc_loop
  import chdr_pkg::*;
  import block_cfg_pkg::*;
();

  localparam int NB      = `NOC_NUM_BLOCKS;
  localparam int LB      = `NOC_LANE_BITS;
  localparam int TIMEOUT = 2000;

  logic        ce_clk = 1'b0;
  logic        i_arst_n;
  axis_beat_t  i_in;
  logic        o_in_ready;
  axis_beat_t  o_out;
  logic        i_out_ready;
  set_bus_t    i_set;
  logic [31:0] rng;
  logic [31:0] bp_rng = 32'd19701;
  logic        bp_on;
  logic        test_end;
  int          test_num;
  int          timeouts;
  int          pending;
  int          errors;
  int          tests_run;
  int          tests_failed;

  noc_loop_top uut (
    .ce_clk      (ce_clk),
    .i_arst_n    (i_arst_n),
    .i_in        (i_in),
    .o_in_ready  (o_in_ready),
    .o_out       (o_out),
    .i_out_ready (i_out_ready),
    .i_set       (i_set)
  );

  noc_loop_checker chk (
    .ce_clk         (ce_clk),
    .i_arst_n       (i_arst_n),
    .i_in           (i_in),
    .i_in_ready     (o_in_ready),
    .i_set          (i_set),
    .i_out          (o_out),
    .i_out_ready    (i_out_ready),
    .i_test_end     (test_end),
    .i_test_num     (test_num),
    .i_timeouts     (timeouts),
    .o_pending      (pending),
    .o_errors       (errors),
    .o_tests_run    (tests_run),
    .o_tests_failed (tests_failed)
  );

  always #4 ce_clk = ~ce_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Value in 0..n-1 from the upper generator bits
  function automatic int pick(input int n);
    rng = lcg_next(rng);
    return int'({16'd0, rng[31:16]}) % n;
  endfunction

  function automatic logic [63:0] rand_word();
    logic [63:0] w;
    rng       = lcg_next(rng);
    w[63:32]  = rng;
    rng       = lcg_next(rng);
    w[31:0]   = rng;
    return w;
  endfunction

  // Ready high about three cycles in four under back-pressure
  always @(posedge ce_clk) begin
    if (bp_on) begin
      bp_rng = lcg_next(bp_rng);
      i_out_ready <= (bp_rng[31:30] != 2'b00);
    end else begin
      i_out_ready <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks entered and left on a rising edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic write_setting(input int blk, input logic [7:0] addr, input logic [31:0] data);
    i_set.stb  <= 1'b1;
    i_set.blk  <= LB'(blk);
    i_set.addr <= addr;
    i_set.data <= data;
    @(posedge ce_clk);
    i_set.stb <= 1'b0;
  endtask

  task automatic send_beat(input logic [63:0] word, input logic last);
    int waited;
    waited = 0;
    if (timeouts == 0) begin
      if (pick(4) == 0) @(posedge ce_clk);
      i_in.data  <= word;
      i_in.last  <= last;
      i_in.valid <= 1'b1;
      @(negedge ce_clk);
      while (!o_in_ready && waited < TIMEOUT) begin
        @(negedge ce_clk);
        waited++;
      end
      if (!o_in_ready) begin
        $display("Timeout: o_in_ready stayed low for %0d cycles", TIMEOUT);
        timeouts++;
      end
      @(posedge ce_clk);
      i_in.valid <= 1'b0;
    end
  endtask

  task automatic send_packet(input int blk, input int beats);
    chdr_hdr_t hdr;
    hdr                 = rand_word();
    hdr.length          = 16'(beats * 8);
    hdr.dst_sid[LB-1:0] = LB'(blk);
    send_beat(hdr, beats == 1);
    for (int i = 1; i < beats; i++) begin
      send_beat(rand_word(), i == beats - 1);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge ce_clk);
    while (pending != 0 && waited < TIMEOUT) begin
      @(posedge ce_clk);
      waited++;
    end
    if (pending != 0) begin
      $display("Timeout: %0d beats still inside the DUT after %0d cycles", pending, TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic end_test();
    wait_drain();
    repeat (4) @(posedge ce_clk);
    test_end <= 1'b1;
    @(posedge ce_clk);
    test_end <= 1'b0;
    @(posedge ce_clk);
  endtask

  initial begin
    i_arst_n    = 1'b0;
    i_in        = '0;
    i_set       = '0;
    i_out_ready = 1'b1;
    bp_on       = 1'b0;
    test_end    = 1'b0;
    test_num    = 0;
    timeouts    = 0;
    rng         = 32'd19701;
    repeat (8) @(posedge ce_clk);
    i_arst_n <= 1'b1;

    test_num <= 1;
    repeat (12) @(posedge ce_clk);
    end_test();

    // Distinct IDs per block, then one packet each
    test_num <= 2;
    for (int b = 0; b < NB; b++) begin
      write_setting(b, `NOC_REG_NEXT_DST, 32'h0000_a000 + 32'(b));
      write_setting(b, `NOC_REG_SRC_SID, 32'h0000_0100 + 32'(b));
    end
    for (int b = 0; b < NB; b++) send_packet(b, 1 + pick(4));
    end_test();

    test_num <= 3;
    repeat (20) send_packet(1, 1 + pick(3));
    wait_drain();
    write_setting(1, `NOC_REG_CLEAR_SEQ, 32'hffff_ffff);
    send_packet(1, 2);
    send_packet(0, 2);
    end_test();

    test_num <= 4;
    bp_on <= 1'b1;
    repeat (200) send_packet(pick(NB), 1 + pick(16));
    end_test();

    // Every third packet is a lone header
    test_num <= 5;
    for (int p = 0; p < 60; p++) send_packet(p % NB, (p % 3 == 0) ? 1 : 1 + pick(6));
    end_test();

    test_num <= 6;
    for (int p = 0; p < 40; p++) begin
      if (p == 20) write_setting(NB - 1, `NOC_REG_NEXT_DST, 32'h0000_b00f);
      send_packet(pick(NB), 1 + pick(8));
    end
    bp_on <= 1'b0;
    end_test();

    repeat (4) @(posedge ce_clk);
    $display("Summary: %0d tests, %0d failed, %0d errors, %0d timeouts",
             tests_run, tests_failed, errors, timeouts);
    if (tests_run == 6 && tests_failed == 0 && errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+source
source/chdr_pkg.sv
source/block_cfg_pkg.sv
source/stream_router.sv
source/loopback_block.sv
source/stream_merger.sv
source/noc_loop_top.sv
test/noc_loop_checker.sv
test/tb_noc_loop.sv

//--- run_sim.sh
#!/bin/sh
# Builds the loopback testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_noc_loop -o sim_noc_loop

out=$(./obj_dir/sim_noc_loop)
echo "$out"

if echo "$out" | grep -Fxq '>>> PASS'; then
  exit 0
fi
exit 1
